// File: Bender.yml
package:
  name: vending_machine

export_include_dirs:
  - include

sources:
  - logic/vending_pkg.sv
  - logic/vendController.sv
  - logic/priceTable.sv
  - logic/scanTimer.sv
  - logic/segmentDisplay.sv
  - logic/vendingMachine.sv
  - target: test
    files:
      - verif/vendController_checker.sv
      - verif/vendingMachine_tb.sv

// File: compile.f
+incdir+include
logic/vending_pkg.sv
logic/vendController.sv
logic/priceTable.sv
logic/scanTimer.sv
logic/segmentDisplay.sv
logic/vendingMachine.sv
verif/vendController_checker.sv
verif/vendingMachine_tb.sv

// File: include/vending_config.svh
`ifndef VENDING_CONFIG_SVH
`define VENDING_CONFIG_SVH

// machine size and credit limit
`define VEND_ITEMS      9
`define VEND_MAX_CREDIT 500

// coin values in cents
`define VEND_COIN_NICKEL  5
`define VEND_COIN_DIME    10
`define VEND_COIN_QUARTER 25
`define VEND_COIN_FIFTY   50
`define VEND_COIN_DOLLAR  100
`define VEND_COIN_FIVE    500

// item prices in cents where a price of zero marks the item as sold out
`define VEND_PRICE_A1 100
`define VEND_PRICE_A2 0
`define VEND_PRICE_A3 125
`define VEND_PRICE_B1 175
`define VEND_PRICE_B2 225
`define VEND_PRICE_B3 250
`define VEND_PRICE_C1 100
`define VEND_PRICE_C2 325
`define VEND_PRICE_C3 375

`define VEND_SCAN_BITS 17 // roughly 1 kHz digit rate from a 100 MHz clock

`endif

// File: logic/priceTable.sv
`default_nettype none

`include "vending_config.svh"

module priceTable (
    input  vending_pkg::amount_t    credit,
    input  vending_pkg::itemIdx_t   selItem,
    output vending_pkg::amount_t    selPrice,
    output logic                    selAffordable,
    output vending_pkg::itemMask_t  ready,
    output vending_pkg::itemMask_t  soldOut
);

    localparam vending_pkg::amount_t PriceList [`VEND_ITEMS] = '{
        `VEND_PRICE_A1, `VEND_PRICE_A2, `VEND_PRICE_A3,
        `VEND_PRICE_B1, `VEND_PRICE_B2, `VEND_PRICE_B3,
        `VEND_PRICE_C1, `VEND_PRICE_C2, `VEND_PRICE_C3
    };

    for (genvar i = 0; i < `VEND_ITEMS; i++) begin : gItem
        assign soldOut[i] = (PriceList[i] == '0);
        assign ready[i]   = (credit >= PriceList[i]) && (PriceList[i] != '0);
    end

    // an index past C3 looks like a sold-out item
    always_comb begin
        if (selItem < `VEND_ITEMS) begin
            selPrice      = PriceList[selItem];
            selAffordable = ready[selItem];
        end else begin
            selPrice      = '0;
            selAffordable = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/scanTimer.sv
`default_nettype none

`include "vending_config.svh"

module scanTimer #(
    parameter int ScanBits = `VEND_SCAN_BITS
) (
    input  logic       clk,
    input  logic       rst,
    output logic [1:0] digitSel
);

    logic [ScanBits+1:0] scanCount; // low bits set the dwell time on each digit

    always_ff @(posedge clk) begin
        if (rst) begin
            scanCount <= '0;
        end else begin
            scanCount <= scanCount + 1'b1;
        end
    end

    assign digitSel = scanCount[ScanBits+1:ScanBits]; // steps 0, 1, 2, 3 and wraps

endmodule

`default_nettype wire

// File: logic/segmentDisplay.sv
`default_nettype none

module segmentDisplay (
    input  vending_pkg::amount_t dispAmount,
    input  logic                 dispNegative,
    input  logic                 dispOn,
    input  logic [1:0]           digitSel,
    output logic [3:0]           anodes,
    output logic [7:0]           segments
);

    logic [3:0] dollars, tens, units;
    logic [6:0] centsPart;
    logic [7:0] litSegs; // active high with dp in bit 7 and g..a below it

    // returns gfedcba with a lit segment as 1
    function automatic logic [6:0] encodeDigit(input logic [3:0] digit);
        case (digit)
            4'd0:    return 7'b0111111;
            4'd1:    return 7'b0000110;
            4'd2:    return 7'b1011011;
            4'd3:    return 7'b1001111;
            4'd4:    return 7'b1100110;
            4'd5:    return 7'b1101101;
            4'd6:    return 7'b1111101;
            4'd7:    return 7'b0000111;
            4'd8:    return 7'b1111111;
            4'd9:    return 7'b1101111;
            default: return 7'b0000000;
        endcase
    endfunction

    // at most 511 cents, so the dollar digit never exceeds 5
    assign dollars   = 4'(dispAmount / 9'd100);
    assign centsPart = 7'(dispAmount % 9'd100);
    assign tens      = 4'(centsPart / 7'd10);
    assign units     = 4'(centsPart % 7'd10);

    always_comb begin
        litSegs = '0;
        case (digitSel)
            2'd0: litSegs[6:0] = encodeDigit(units);
            2'd1: litSegs[6:0] = encodeDigit(tens);
            2'd2: begin
                litSegs[6:0] = encodeDigit(dollars);
                litSegs[7]   = 1'b1; // point after the dollars
            end
            default: litSegs[6] = dispNegative; // minus sign is segment g alone
        endcase
        if (!dispOn) begin
            litSegs = '0;
        end
    end

    assign anodes   = ~(4'b0001 << digitSel); // digit 3 is leftmost
    assign segments = ~litSegs;

endmodule

`default_nettype wire

// File: logic/vendController.sv
`default_nettype none

`include "vending_config.svh"

module vendController (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    coinStrobe,
    input  vending_pkg::coin_e      coinKind,
    input  logic                    selectStrobe,
    input  vending_pkg::itemIdx_t   selItem,
    input  logic                    cancelStrobe,
    input  vending_pkg::amount_t    selPrice,
    input  logic                    selAffordable,
    output vending_pkg::amount_t    credit,
    output vending_pkg::amount_t    dispAmount,
    output logic                    dispNegative,
    output logic                    dispOn,
    output vending_pkg::itemMask_t  dispensed
);

    vending_pkg::vendState_e state, stateNext;
    vending_pkg::amount_t    creditNext, dispAmountNext, coinValue;
    vending_pkg::itemMask_t  dispensedNext;
    logic                    dispNegativeNext, dispOnNext;
    logic                    coinValid, coinFits;
    logic [9:0]              coinSum; // one bit wider so a large coin cannot wrap

    always_comb begin
        coinValid = 1'b1;
        case (coinKind)
            vending_pkg::coinNickel:  coinValue = vending_pkg::amount_t'(`VEND_COIN_NICKEL);
            vending_pkg::coinDime:    coinValue = vending_pkg::amount_t'(`VEND_COIN_DIME);
            vending_pkg::coinQuarter: coinValue = vending_pkg::amount_t'(`VEND_COIN_QUARTER);
            vending_pkg::coinFifty:   coinValue = vending_pkg::amount_t'(`VEND_COIN_FIFTY);
            vending_pkg::coinDollar:  coinValue = vending_pkg::amount_t'(`VEND_COIN_DOLLAR);
            vending_pkg::coinFive:    coinValue = vending_pkg::amount_t'(`VEND_COIN_FIVE);
            default: begin
                coinValue = '0; // unused opcodes are treated as a rejected coin
                coinValid = 1'b0;
            end
        endcase
    end

    assign coinSum  = {1'b0, credit} + {1'b0, coinValue};
    assign coinFits = coinValid && (coinSum <= 10'(`VEND_MAX_CREDIT));

    // cancel beats select, select beats coin
    always_comb begin
        stateNext        = state;
        creditNext       = credit;
        dispensedNext    = dispensed;
        dispOnNext       = dispOn;
        dispAmountNext   = dispAmount;
        dispNegativeNext = dispNegative;
        if (cancelStrobe) begin
            dispAmountNext   = credit; // the refund is whatever was inserted
            dispNegativeNext = 1'b0;
            dispOnNext       = 1'b1;
            creditNext       = '0;
            dispensedNext    = '0;
            stateNext        = vending_pkg::stShow;
        end else if (selectStrobe) begin
            dispOnNext = 1'b1;
            case (state)
                vending_pkg::stCredit: begin
                    if (selAffordable) begin
                        dispAmountNext   = credit - selPrice; // change
                        dispNegativeNext = 1'b0;
                        creditNext       = '0;
                        dispensedNext    = vending_pkg::itemMask_t'(1) << selItem;
                        stateNext        = vending_pkg::stShow;
                    end else begin
                        // sold-out items price at zero so the shortfall clamps to zero
                        dispAmountNext   = (selPrice > credit) ? selPrice - credit : '0;
                        dispNegativeNext = 1'b1;
                    end
                end
                default: begin
                    dispAmountNext   = selPrice; // no credit, so this is a price query
                    dispNegativeNext = 1'b0;
                    stateNext        = vending_pkg::stIdle;
                end
            endcase
        end else if (coinStrobe && coinFits) begin
            creditNext       = coinSum[8:0];
            dispAmountNext   = coinSum[8:0];
            dispNegativeNext = 1'b0;
            dispOnNext       = 1'b1;
            dispensedNext    = '0; // a new purchase starts, drop the last dispensed LED
            stateNext        = vending_pkg::stCredit;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= vending_pkg::stIdle;
            credit    <= '0;
            dispensed <= '0;
            dispOn    <= 1'b0;
        end else begin
            state     <= stateNext;
            credit    <= creditNext;
            dispensed <= dispensedNext;
            dispOn    <= dispOnNext;
        end
    end

    always_ff @(posedge clk) begin
        dispAmount   <= dispAmountNext;
        dispNegative <= dispNegativeNext;
    end

endmodule

`default_nettype wire

// File: logic/vendingMachine.sv
`default_nettype none

`include "vending_config.svh"

module vendingMachine #(
    parameter int ScanBits = `VEND_SCAN_BITS
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    coinStrobe,
    input  vending_pkg::coin_e      coinKind,
    input  logic                    selectStrobe,
    input  vending_pkg::itemIdx_t   selItem,
    input  logic                    cancelStrobe,
    output vending_pkg::itemMask_t  ready,
    output vending_pkg::itemMask_t  soldOut,
    output vending_pkg::itemMask_t  dispensed,
    output logic [3:0]              anodes,
    output logic [7:0]              segments
);

    vending_pkg::amount_t credit, selPrice, dispAmount;
    logic                 selAffordable, dispNegative, dispOn;
    logic [1:0]           digitSel;

    vendController vendController_inst (
        .clk           (clk),
        .rst           (rst),
        .coinStrobe    (coinStrobe),
        .coinKind      (coinKind),
        .selectStrobe  (selectStrobe),
        .selItem       (selItem),
        .cancelStrobe  (cancelStrobe),
        .selPrice      (selPrice),
        .selAffordable (selAffordable),
        .credit        (credit),
        .dispAmount    (dispAmount),
        .dispNegative  (dispNegative),
        .dispOn        (dispOn),
        .dispensed     (dispensed)
    );

    // price lookup works straight from the registered credit
    priceTable priceTable_inst (
        .credit        (credit),
        .selItem       (selItem),
        .selPrice      (selPrice),
        .selAffordable (selAffordable),
        .ready         (ready),
        .soldOut       (soldOut)
    );

    scanTimer #(
        .ScanBits (ScanBits)
    ) scanTimer_inst (
        .clk      (clk),
        .rst      (rst),
        .digitSel (digitSel)
    );

    segmentDisplay segmentDisplay_inst (
        .dispAmount   (dispAmount),
        .dispNegative (dispNegative),
        .dispOn       (dispOn),
        .digitSel     (digitSel),
        .anodes       (anodes),
        .segments     (segments)
    );

endmodule

`default_nettype wire

// File: logic/vending_pkg.sv
`default_nettype none

`include "vending_config.svh"

package vending_pkg;

    typedef logic [8:0] amount_t; // cents, covers the 500 cent limit
    typedef logic [3:0] itemIdx_t; // 0 is A1, 8 is C3
    typedef logic [`VEND_ITEMS-1:0] itemMask_t;

    typedef enum logic [2:0] {
        coinNickel,
        coinDime,
        coinQuarter,
        coinFifty,
        coinDollar,
        coinFive
    } coin_e;

    // stShow holds a change or refund figure on the display with no credit left
    typedef enum logic [1:0] {
        stIdle,
        stCredit,
        stShow
    } vendState_e;

endpackage

`default_nettype wire

// File: verif/vendController_checker.sv
`default_nettype none

`include "vending_config.svh"

module vendController_checker (
    input logic                   clk,
    input logic                   rst,
    input logic                   cancelStrobe,
    input vending_pkg::amount_t   credit,
    input vending_pkg::itemMask_t dispensed
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0; // counts failed assertions

    creditLimit: assert property (@(posedge clk) disable iff (rst)
        credit <= `VEND_MAX_CREDIT) else begin
        failCount++;
        $error("credit is above the limit");
    end

    // only the item just bought may have its LED lit
    singleDispense: assert property (@(posedge clk) disable iff (rst)
        $onehot0(dispensed)) else begin
        failCount++;
        $error("more than one dispensed bit is set");
    end

    cancelClears: assert property (@(posedge clk) disable iff (rst)
        cancelStrobe |=> credit == '0) else begin
        failCount++;
        $error("credit is not zero after a cancel");
    end

endmodule

bind vendController vendController_checker vendController_checker_inst (
    .clk          (clk),
    .rst          (rst),
    .cancelStrobe (cancelStrobe),
    .credit       (credit),
    .dispensed    (dispensed)
);

`default_nettype wire

// File: verif/vendingMachine_tb.sv
`default_nettype none

`include "vending_config.svh"

module vendingMachine_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int OpCoin = 0;
    localparam int OpSelect = 1;
    localparam int OpCancel = 2;
    localparam int OpNone = 3;
    localparam int ScanTimeout = 40; // one full scan is 16 cycles with ScanBits at 2
    localparam int Prices [`VEND_ITEMS] = '{`VEND_PRICE_A1, `VEND_PRICE_A2, `VEND_PRICE_A3,
        `VEND_PRICE_B1, `VEND_PRICE_B2, `VEND_PRICE_B3,
        `VEND_PRICE_C1, `VEND_PRICE_C2, `VEND_PRICE_C3};
    localparam int CoinValues [6] = '{`VEND_COIN_NICKEL, `VEND_COIN_DIME, `VEND_COIN_QUARTER,
        `VEND_COIN_FIFTY, `VEND_COIN_DOLLAR, `VEND_COIN_FIVE};
    localparam logic [6:0] DigitSegs [10] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66,
        7'h6d, 7'h7d, 7'h07, 7'h7f, 7'h6f}; // gfedcba with a lit segment as 1

    typedef struct packed {
        vending_pkg::amount_t   credit;
        vending_pkg::amount_t   amount;
        logic                   negative;
        logic                   on;
        vending_pkg::itemMask_t ready;
        vending_pkg::itemMask_t soldOut;
        vending_pkg::itemMask_t dispensed;
    } refState_t;

    logic                   clk, rst, coinStrobe, selectStrobe, cancelStrobe;
    vending_pkg::coin_e     coinKind;
    vending_pkg::itemIdx_t  selItem;
    vending_pkg::itemMask_t ready, soldOut, dispensed;
    logic [3:0]             anodes;
    logic [7:0]             segments;
    logic [31:0]            lfsr = 32'hf7603c3d;
    refState_t              model;
    int                     assertFails;

    vendingMachine #(
        .ScanBits (2)
    ) vendingMachine_inst (
        .clk          (clk),
        .rst          (rst),
        .coinStrobe   (coinStrobe),
        .coinKind     (coinKind),
        .selectStrobe (selectStrobe),
        .selItem      (selItem),
        .cancelStrobe (cancelStrobe),
        .ready        (ready),
        .soldOut      (soldOut),
        .dispensed    (dispensed),
        .anodes       (anodes),
        .segments     (segments)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once for each bit handed out
    function automatic int randBits(int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    // expected machine state after one operation
    function automatic refState_t applyRules(refState_t s, int op, int arg);
        refState_t n;
        int        price;
        n = s;
        price = (op == OpSelect) ? Prices[arg] : 0;
        if (op == OpCancel) begin
            n.amount    = s.credit; // refund is the whole credit
            n.negative  = 1'b0;
            n.on        = 1'b1;
            n.credit    = '0;
            n.dispensed = '0;
        end else if (op == OpSelect) begin
            n.on       = 1'b1;
            n.negative = 1'b0;
            if (s.credit == 0) begin
                n.amount = vending_pkg::amount_t'(price);
            end else if (price != 0 && s.credit >= price) begin
                n.amount         = vending_pkg::amount_t'(s.credit - price);
                n.credit         = '0;
                n.dispensed      = '0;
                n.dispensed[arg] = 1'b1;
            end else begin
                // shortfall clamps at zero, which covers a sold-out item
                n.amount   = (price > s.credit) ? vending_pkg::amount_t'(price - s.credit) : '0;
                n.negative = 1'b1;
            end
        end else if (op == OpCoin && s.credit + CoinValues[arg] <= `VEND_MAX_CREDIT) begin
            n.credit    = vending_pkg::amount_t'(s.credit + CoinValues[arg]);
            n.amount    = n.credit;
            n.negative  = 1'b0;
            n.on        = 1'b1;
            n.dispensed = '0;
        end
        for (int i = 0; i < `VEND_ITEMS; i++) begin
            n.soldOut[i] = (Prices[i] == 0);
            n.ready[i]   = (Prices[i] != 0) && (n.credit >= Prices[i]);
        end
        return n;
    endfunction

    task automatic failRun(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkAmount(string name,
                               vending_pkg::amount_t exp, vending_pkg::amount_t act);
        if (exp !== act) begin
            failRun($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic checkMask(string name,
                             vending_pkg::itemMask_t exp, vending_pkg::itemMask_t act);
        if (exp !== act) begin
            failRun($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic checkSign(string name, logic exp, logic act);
        if (exp !== act) begin
            failRun($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
        end
    endtask

    // collects every digit of one scan at the falling edge, then decodes sign and D.DD
    task automatic readDisplay(output vending_pkg::amount_t amt, output logic neg,
                               output logic blank);
        logic [7:0] digs [4];
        logic [3:0] seen;
        int         val [3];
        int         cycles;
        seen   = '0;
        cycles = 0;
        while (seen != 4'hf) begin
            if (cycles == ScanTimeout) begin
                failRun("the display scan did not reach all four digits in time");
            end
            @(negedge clk);
            cycles++;
            for (int k = 0; k < 4; k++) begin
                if (anodes == ~(4'b0001 << k)) begin
                    digs[k] = segments;
                    seen[k] = 1'b1;
                end
            end
        end
        blank = ((digs[0] & digs[1] & digs[2] & digs[3]) == 8'hff);
        neg   = (digs[3] == 8'hbf); // segment g alone
        amt   = '0;
        if (!blank) begin
            if (digs[3] != 8'hff && !neg) begin
                failRun("the sign digit shows something other than blank or minus");
            end
            for (int k = 0; k < 3; k++) begin
                val[k] = -1;
                for (int d = 0; d < 10; d++) begin
                    if ((~digs[k][6:0]) == DigitSegs[d]) begin
                        val[k] = d;
                    end
                end
                if (val[k] < 0 || digs[k][7] !== logic'(k != 2)) begin
                    failRun("a digit shows a pattern that is not a number");
                end
            end
            amt = vending_pkg::amount_t'(val[2] * 100 + val[1] * 10 + val[0]);
        end
    endtask

    task automatic runStep(string name, int op, int arg);
        vending_pkg::amount_t amt;
        logic                 neg, blank;
        if (op != OpNone) begin
            @(posedge clk);
            #1;
            coinStrobe   = (op == OpCoin);
            selectStrobe = (op == OpSelect);
            cancelStrobe = (op == OpCancel);
            if (op == OpCoin) begin
                coinKind = vending_pkg::coin_e'(arg);
            end
            if (op == OpSelect) begin
                selItem = vending_pkg::itemIdx_t'(arg);
            end
            @(posedge clk);
            #1;
            coinStrobe   = 1'b0;
            selectStrobe = 1'b0;
            cancelStrobe = 1'b0;
        end
        model = applyRules(model, op, arg);
        readDisplay(amt, neg, blank);
        checkSign({name, " blank"}, !model.on, blank);
        if (model.on) begin
            checkAmount({name, " display"}, model.amount, amt);
            checkSign({name, " sign"}, model.negative, neg);
        end
        checkAmount({name, " credit"}, model.credit, vendingMachine_inst.credit);
        checkMask({name, " ready"}, model.ready, ready);
        checkMask({name, " soldOut"}, model.soldOut, soldOut);
        checkMask({name, " dispensed"}, model.dispensed, dispensed);
    endtask

    initial begin
        rst          = 1'b1;
        coinStrobe   = 1'b0;
        coinKind     = vending_pkg::coinNickel;
        selectStrobe = 1'b0;
        selItem      = '0;
        cancelStrobe = 1'b0;
        model        = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        runStep("after reset", OpNone, 0);
        for (int i = 0; i < `VEND_ITEMS; i++) begin
            runStep("price query", OpSelect, i);
        end
        repeat (20) begin
            runStep("random coin", OpCoin, randBits(3) % 6);
        end
        runStep("coin over limit", OpCoin, int'(vending_pkg::coinFive));
        runStep("cancel refund", OpCancel, 0);
        runStep("small coin", OpCoin, int'(vending_pkg::coinDime));
        runStep("sold out select", OpSelect, 1);
        runStep("short select", OpSelect, 8);
        repeat (6) begin
            runStep("random select", OpSelect, randBits(4) % 9);
        end
        runStep("dollar coin", OpCoin, int'(vending_pkg::coinDollar));
        runStep("dollar coin", OpCoin, int'(vending_pkg::coinDollar));
        runStep("purchase", OpSelect, 0); // 210 cents buys A1 and leaves 110 change
        runStep("coin after purchase", OpCoin, int'(vending_pkg::coinNickel));
        runStep("cancel after coin", OpCancel, 0);
        runStep("select after cancel", OpSelect, 2);

        assertFails =
            vendingMachine_inst.vendController_inst.vendController_checker_inst.failCount;
        if (assertFails == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "controller assertions reported errors");
        end
    end

endmodule

`default_nettype wire
